/* include/wisc_macros.svh */
/*
   Shared constants for the WISC decode and execute datapath.
   Holds the word width, the 5-bit opcodes and the 2-bit function codes.
   Include it wherever these values are needed.
*/
`ifndef WISC_MACROS_SVH
`define WISC_MACROS_SVH

`define WORD_W 16

// I-format arithmetic and logic
`define OP_ADDI  5'b01000
`define OP_SUBI  5'b01001
`define OP_XORI  5'b01010
`define OP_ANDNI 5'b01011

// immediate shifts and rotates
`define OP_ROLI  5'b10100
`define OP_SLLI  5'b10101
`define OP_RORI  5'b10110
`define OP_SRLI  5'b10111

// memory
`define OP_ST    5'b10000
`define OP_LD    5'b10001

// R-format groups, function bits pick the operation
`define OP_RALU  5'b11011
`define OP_RSHF  5'b11010
`define OP_BTR   5'b11001

// set instructions
`define OP_SEQ   5'b11100
`define OP_SLT   5'b11101
`define OP_SLE   5'b11110
`define OP_SCO   5'b11111

// branches on Rs
`define OP_BEQZ  5'b01100
`define OP_BNEZ  5'b01101
`define OP_BLTZ  5'b01110
`define OP_BGEZ  5'b01111

// immediate loads
`define OP_LBI   5'b11000
`define OP_SLBI  5'b10010

// jumps
`define OP_J     5'b00100
`define OP_JR    5'b00101
`define OP_JAL   5'b00110
`define OP_JALR  5'b00111

// function bits of the R-type ALU group
`define FN_ADD   2'b00
`define FN_SUB   2'b01
`define FN_XOR   2'b10
`define FN_ANDN  2'b11

// function bits of the R-type shift group
`define FN_ROL   2'b00
`define FN_SLL   2'b01
`define FN_ROR   2'b10
`define FN_SRL   2'b11

`endif

/* src/wiscPkg.sv */
/*
   Types shared by the decoder, the execute stage and the testbench.
   Import with wiscPkg::* in the module header.
*/
`include "wisc_macros.svh"

package wiscPkg;

   typedef logic [`WORD_W-1:0] wordT;
   typedef logic [4:0]         opcodeT;
   typedef logic [2:0]         aluOpT;
   typedef logic [2:0]         resSelT;
   typedef logic [1:0]         pcSelT;
   typedef logic [1:0]         condT;

   // alu operations, low four follow opcode bits 12:11 of the shifts
   localparam aluOpT aluRol  = 3'd0;
   localparam aluOpT aluSll  = 3'd1;
   localparam aluOpT aluRor  = 3'd2;
   localparam aluOpT aluSrl  = 3'd3;
   localparam aluOpT aluAdd  = 3'd4;
   localparam aluOpT aluAnd  = 3'd5;
   localparam aluOpT aluXor  = 3'd6;
   localparam aluOpT aluPass = 3'd7;

   // result select
   localparam resSelT resAlu  = 3'd0;
   localparam resSelT resSet  = 3'd1;
   localparam resSelT resBtr  = 3'd2;
   localparam resSelT resLink = 3'd3;
   localparam resSelT resImm  = 3'd4;
   localparam resSelT resZero = 3'd5;

   // next-pc select
   localparam pcSelT pcSeq    = 2'd0;
   localparam pcSelT pcBranch = 2'd1;
   localparam pcSelT pcRel    = 2'd2;
   localparam pcSelT pcReg    = 2'd3;

   // condition codes, equal to opcode bits 12:11 of branch and set
   localparam condT condEq = 2'd0;
   localparam condT condNe = 2'd1;
   localparam condT condLt = 2'd2;
   localparam condT condGe = 2'd3;
   localparam condT setEq  = 2'd0;
   localparam condT setLt  = 2'd1;
   localparam condT setLe  = 2'd2;
   localparam condT setCo  = 2'd3;

endpackage

/* src/claAdder16.sv */
/*
   16-bit carry-lookahead adder made of four 4-bit groups.
   Group generate and propagate feed a second lookahead level.
   Used for the ALU sum and for PC-relative targets.
*/
`timescale 1ns/1ps

module claAdder16 import wiscPkg::*; (
   input  wordT a,
   input  wordT b,
   input  logic cin,
   output wordT sum,
   output logic cout
);

   logic [15:0] g, p, c;
   logic [3:0]  gg, gp;
   logic [4:0]  gc;

   assign g = a & b;
   assign p = a ^ b;

   // group generate and propagate
   for (genvar i = 0; i < 4; i++) begin : grp
      assign gg[i] = g[4*i+3] | (p[4*i+3] & g[4*i+2])
                   | (p[4*i+3] & p[4*i+2] & g[4*i+1])
                   | (p[4*i+3] & p[4*i+2] & p[4*i+1] & g[4*i]);
      assign gp[i] = &p[4*i+3:4*i];

      // carries inside the group
      assign c[4*i]   = gc[i];
      assign c[4*i+1] = g[4*i] | (p[4*i] & gc[i]);
      assign c[4*i+2] = g[4*i+1] | (p[4*i+1] & g[4*i]) | (p[4*i+1] & p[4*i] & gc[i]);
      assign c[4*i+3] = g[4*i+2] | (p[4*i+2] & g[4*i+1]) | (p[4*i+2] & p[4*i+1] & g[4*i])
                      | (p[4*i+2] & p[4*i+1] & p[4*i] & gc[i]);
   end

   // second level lookahead across the groups
   assign gc[0] = cin;
   assign gc[1] = gg[0] | (gp[0] & cin);
   assign gc[2] = gg[1] | (gp[1] & gg[0]) | (gp[1] & gp[0] & cin);
   assign gc[3] = gg[2] | (gp[2] & gg[1]) | (gp[2] & gp[1] & gg[0])
                | (gp[2] & gp[1] & gp[0] & cin);
   assign gc[4] = gg[3] | (gp[3] & gg[2]) | (gp[3] & gp[2] & gg[1])
                | (gp[3] & gp[2] & gp[1] & gg[0]) | (&gp & cin);

   assign sum  = p ^ c;
   assign cout = gc[4];

endmodule

/* src/aluCore.sv */
/*
   16-bit ALU with optional inversion of either input.
   Supports rotate, shift, add, and, xor and pass-A.
   Shift and rotate amounts come from the low 4 bits of inB.
   cout and ofl describe the adder, zero describes out.
*/
`timescale 1ns/1ps

module aluCore import wiscPkg::*; (
   input  wordT  inA,
   input  wordT  inB,
   input  aluOpT op,
   input  logic  invA,
   input  logic  invB,
   input  logic  cin,
   output wordT  out,
   output logic  cout,
   output logic  zero,
   output logic  ofl
);

   wordT        a, b;
   wordT        addSum;
   logic [3:0]  amt;
   logic [31:0] rolWide, rorWide;

   // inversion ahead of every operation
   assign a = invA ? ~inA : inA;
   assign b = invB ? ~inB : inB;

   assign amt = b[3:0];

   claAdder16 adder (
      .a   (a),
      .b   (b),
      .cin (cin),
      .sum (addSum),
      .cout(cout)
   );

   // doubled word makes rotates a plain shift
   assign rolWide = {a, a} << amt;
   assign rorWide = {a, a} >> amt;

   always_comb begin
      case (op)
         aluRol:  out = rolWide[31:16];
         aluSll:  out = a << amt;
         aluRor:  out = rorWide[15:0];
         aluSrl:  out = a >> amt;
         aluAdd:  out = addSum;
         aluAnd:  out = a & b;
         aluXor:  out = a ^ b;
         default: out = a;
      endcase
   end

   // signed overflow, operands agree in sign but the sum does not
   assign ofl  = (a[15] == b[15]) && (addSum[15] != a[15]);
   assign zero = (out == '0);

endmodule

/* src/instrDecode.sv */
/*
   Combinational decoder for one WISC instruction word.
   Produces ALU controls, the extended immediate and the result and PC selects.
   Opcodes it does not know decode as a no-op with a zero result.
*/
`timescale 1ns/1ps
`include "wisc_macros.svh"

module instrDecode import wiscPkg::*; (
   input  wordT   instr,
   output aluOpT  aluOp,
   output logic   invA,
   output logic   invB,
   output logic   useImm,
   output logic   shiftImm,
   output logic   slbi,
   output logic   isSet,
   output logic   memRead,
   output logic   memWrite,
   output logic   ofEnable,
   output wordT   immVal,
   output resSelT resSel,
   output pcSelT  pcSel,
   output condT   cond
);

   opcodeT op;
   wordT   imm5s, imm5z, imm8s, imm8z, disp11s;

   assign op = instr[15:11];

   // immediate forms
   assign imm5s   = {{11{instr[4]}}, instr[4:0]};
   assign imm5z   = {11'b0, instr[4:0]};
   assign imm8s   = {{8{instr[7]}}, instr[7:0]};
   assign imm8z   = {8'b0, instr[7:0]};
   assign disp11s = {{5{instr[10]}}, instr[10:0]};

   always_comb begin
      // no-op defaults
      aluOp    = aluPass;
      invA     = 1'b0;
      invB     = 1'b0;
      useImm   = 1'b0;
      shiftImm = 1'b0;
      slbi     = 1'b0;
      isSet    = 1'b0;
      memRead  = 1'b0;
      memWrite = 1'b0;
      ofEnable = 1'b0;
      immVal   = '0;
      resSel   = resZero;
      pcSel    = pcSeq;
      cond     = condEq;
      case (op)
         `OP_ADDI, `OP_SUBI: begin
            // subi is imm - rs, so rs is inverted with carry in
            aluOp    = aluAdd;
            invA     = (op == `OP_SUBI);
            useImm   = 1'b1;
            immVal   = imm5s;
            ofEnable = 1'b1;
            resSel   = resAlu;
         end
         `OP_XORI, `OP_ANDNI: begin
            aluOp  = (op == `OP_XORI) ? aluXor : aluAnd;
            invB   = (op == `OP_ANDNI);
            useImm = 1'b1;
            immVal = imm5z;
            resSel = resAlu;
         end
         `OP_ROLI, `OP_SLLI, `OP_RORI, `OP_SRLI: begin
            aluOp    = {1'b0, op[1:0]};
            shiftImm = 1'b1;
            immVal   = imm5z;
            resSel   = resAlu;
         end
         `OP_ST, `OP_LD: begin
            // address is rs + sign-extended imm5
            aluOp    = aluAdd;
            useImm   = 1'b1;
            immVal   = imm5s;
            memWrite = (op == `OP_ST);
            memRead  = (op == `OP_LD);
            resSel   = resAlu;
         end
         `OP_RALU: begin
            resSel = resAlu;
            case (instr[1:0])
               `FN_ADD: begin
                  aluOp    = aluAdd;
                  ofEnable = 1'b1;
               end
               `FN_SUB: begin
                  // rt - rs
                  aluOp    = aluAdd;
                  invA     = 1'b1;
                  ofEnable = 1'b1;
               end
               `FN_XOR:  aluOp = aluXor;
               default: begin
                  aluOp = aluAnd;
                  invB  = 1'b1;
               end
            endcase
         end
         `OP_RSHF: begin
            aluOp  = {1'b0, instr[1:0]};
            resSel = resAlu;
         end
         `OP_BTR:  resSel = resBtr;
         `OP_SEQ, `OP_SLT, `OP_SLE, `OP_SCO: begin
            // adder runs rs + rt for the carry of sco
            aluOp  = aluAdd;
            isSet  = 1'b1;
            cond   = op[1:0];
            resSel = resSet;
         end
         `OP_BEQZ, `OP_BNEZ, `OP_BLTZ, `OP_BGEZ: begin
            immVal = imm8s;
            cond   = op[1:0];
            pcSel  = pcBranch;
         end
         `OP_LBI: begin
            immVal = imm8s;
            resSel = resImm;
         end
         `OP_SLBI: begin
            // low byte of rs<<8 is zero, so xor acts as or
            aluOp  = aluXor;
            slbi   = 1'b1;
            useImm = 1'b1;
            immVal = imm8z;
            resSel = resAlu;
         end
         `OP_J, `OP_JAL: begin
            immVal = disp11s;
            pcSel  = pcRel;
            resSel = (op == `OP_JAL) ? resLink : resZero;
         end
         `OP_JR, `OP_JALR: begin
            aluOp  = aluAdd;
            useImm = 1'b1;
            immVal = imm8s;
            pcSel  = pcReg;
            resSel = (op == `OP_JALR) ? resLink : resZero;
         end
         default: ;
      endcase
   end

endmodule

/* src/executeStage.sv */
/*
   Combinational execute stage.
   Muxes the ALU operands, evaluates set and branch conditions,
   picks the result and resolves the next PC.
   Flags are taken from the final result, ofl only where enabled.
*/
`timescale 1ns/1ps

module executeStage import wiscPkg::*; (
   input  wordT   regData1,
   input  wordT   regData2,
   input  wordT   incPc,
   input  wordT   immVal,
   input  aluOpT  aluOp,
   input  logic   invA,
   input  logic   invB,
   input  logic   useImm,
   input  logic   shiftImm,
   input  logic   slbi,
   input  resSelT resSel,
   input  pcSelT  pcSel,
   input  condT   cond,
   input  logic   isSet,
   input  logic   memRead,
   input  logic   memWrite,
   input  logic   ofEnable,
   output wordT   result,
   output wordT   newPc,
   output logic   zero,
   output logic   ofl
);

   wordT opA, opB, aluOut, relTarget, btrOut;
   logic aluCout, aluZero, aluOfl;
   logic setHit, branchHit, condTrue;

   // slbi moves rs up a byte before the immediate is merged in
   assign opA = slbi ? (regData1 << 8) : regData1;

   // immediate shifts take only the 4-bit amount
   assign opB = shiftImm ? {12'b0, immVal[3:0]} : (useImm ? immVal : regData2);

   aluCore alu (
      .inA (opA),
      .inB (opB),
      .op  (aluOp),
      .invA(invA),
      .invB(invB),
      .cin (invA | invB),
      .out (aluOut),
      .cout(aluCout),
      .zero(aluZero),
      .ofl (aluOfl)
   );

   // target for branches and pc-relative jumps
   claAdder16 pcAdder (
      .a   (incPc),
      .b   (immVal),
      .cin (1'b0),
      .sum (relTarget),
      .cout()
   );

   always_comb begin
      for (int i = 0; i < 16; i++) begin
         btrOut[i] = regData1[15-i];
      end
   end

   // set conditions compare rs against rt
   always_comb begin
      case (cond)
         setEq:   setHit = (regData1 == regData2);
         setLt:   setHit = ($signed(regData1) < $signed(regData2));
         setLe:   setHit = ($signed(regData1) <= $signed(regData2));
         default: setHit = aluCout;
      endcase
   end

   // branches see rs passed straight through the alu
   always_comb begin
      case (cond)
         condEq:  branchHit = aluZero;
         condNe:  branchHit = !aluZero;
         condLt:  branchHit = aluOut[15];
         default: branchHit = !aluOut[15];
      endcase
   end

   assign condTrue = isSet ? setHit : branchHit;

   always_comb begin
      case (resSel)
         resAlu:  result = aluOut;
         resSet:  result = {15'b0, condTrue};
         resBtr:  result = btrOut;
         resLink: result = incPc;
         resImm:  result = immVal;
         default: result = '0;
      endcase
   end

   always_comb begin
      case (pcSel)
         pcBranch: newPc = condTrue ? relTarget : incPc;
         pcRel:    newPc = relTarget;
         // jr and jalr add the immediate to rs in the alu
         pcReg:    newPc = aluOut;
         default:  newPc = incPc;
      endcase
   end

   assign zero = (result == '0);

   // memory ops never report overflow on the address add
   assign ofl = ofEnable & aluOfl & !(memRead | memWrite);

endmodule

/* src/resultStage.sv */
/*
   Output register behind the execute stage.
   Data is captured on each valid instruction and held otherwise.
   Valid and flag outputs pulse for one cycle per instruction.
*/
`timescale 1ns/1ps

module resultStage import wiscPkg::*; (
   input  logic clk,
   input  logic rstN,
   input  logic instrValid,
   input  wordT result,
   input  wordT newPc,
   input  logic zero,
   input  logic ofl,
   input  logic memRead,
   input  logic memWrite,
   output logic outValid,
   output logic zeroOut,
   output logic oflOut,
   output logic memReadOut,
   output logic memWriteOut,
   output wordT resultOut,
   output wordT newPcOut
);

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         outValid    <= 1'b0;
         zeroOut     <= 1'b0;
         oflOut      <= 1'b0;
         memReadOut  <= 1'b0;
         memWriteOut <= 1'b0;
         resultOut   <= '0;
         newPcOut    <= '0;
      end else begin
         // flags drop on idle cycles
         outValid    <= instrValid;
         zeroOut     <= instrValid & zero;
         oflOut      <= instrValid & ofl;
         memReadOut  <= instrValid & memRead;
         memWriteOut <= instrValid & memWrite;
         if (instrValid) begin
            resultOut <= result;
            newPcOut  <= newPc;
         end
      end
   end

endmodule

/* src/wiscExecTop.sv */
/*
   Decode and execute top level.
   Decoder and execute stage are combinational, the result stage adds
   one cycle, so outputs follow each valid instruction by one clock.
*/
`timescale 1ns/1ps

module wiscExecTop import wiscPkg::*; (
   input  logic clk,
   input  logic rstN,
   input  logic instrValid,
   input  wordT instr,
   input  wordT regData1,
   input  wordT regData2,
   input  wordT incPc,
   output logic outValid,
   output wordT result,
   output wordT newPc,
   output logic zero,
   output logic ofl,
   output logic memRead,
   output logic memWrite
);

   aluOpT  aluOp;
   logic   invA, invB, useImm, shiftImm, slbi, isSet, ofEnable;
   logic   decMemRead, decMemWrite;
   wordT   immVal, exResult, exNewPc;
   resSelT resSel;
   pcSelT  pcSel;
   condT   cond;
   logic   exZero, exOfl;

   instrDecode decode (
      .instr   (instr),
      .aluOp   (aluOp),
      .invA    (invA),
      .invB    (invB),
      .useImm  (useImm),
      .shiftImm(shiftImm),
      .slbi    (slbi),
      .isSet   (isSet),
      .memRead (decMemRead),
      .memWrite(decMemWrite),
      .ofEnable(ofEnable),
      .immVal  (immVal),
      .resSel  (resSel),
      .pcSel   (pcSel),
      .cond    (cond)
   );

   executeStage execute (
      .regData1(regData1),
      .regData2(regData2),
      .incPc   (incPc),
      .immVal  (immVal),
      .aluOp   (aluOp),
      .invA    (invA),
      .invB    (invB),
      .useImm  (useImm),
      .shiftImm(shiftImm),
      .slbi    (slbi),
      .resSel  (resSel),
      .pcSel   (pcSel),
      .cond    (cond),
      .isSet   (isSet),
      .memRead (decMemRead),
      .memWrite(decMemWrite),
      .ofEnable(ofEnable),
      .result  (exResult),
      .newPc   (exNewPc),
      .zero    (exZero),
      .ofl     (exOfl)
   );

   resultStage outReg (
      .clk        (clk),
      .rstN       (rstN),
      .instrValid (instrValid),
      .result     (exResult),
      .newPc      (exNewPc),
      .zero       (exZero),
      .ofl        (exOfl),
      .memRead    (decMemRead),
      .memWrite   (decMemWrite),
      .outValid   (outValid),
      .zeroOut    (zero),
      .oflOut     (ofl),
      .memReadOut (memRead),
      .memWriteOut(memWrite),
      .resultOut  (result),
      .newPcOut   (newPc)
   );

endmodule

/* tests/execTb.sv */
/*
   Testbench for the WISC decode and execute top level.
   Drives directed and random instructions, predicts each registered result
   with a reference model and compares on every outValid pulse.
   Run through run.sh with Verilator.
*/
`timescale 1ns/1ps
`include "wisc_macros.svh"

module execTb import wiscPkg::*;;

   typedef struct packed {
      wordT instr;
      wordT result;
      wordT newPc;
      logic zero;
      logic ofl;
      logic memRead;
      logic memWrite;
   } expT;

   logic clk = 1'b0;
   logic rstN;
   logic instrValid;
   wordT instr, regData1, regData2, incPc;
   logic outValid, zero, ofl, memRead, memWrite;
   wordT result, newPc;

   expT         expQ[$];
   logic        validSeen = 1'b0;
   logic [31:0] seedRet;
   int          checkCnt = 0;
   int          mismatchCnt = 0;
   int          otherErrCnt = 0;

   wiscExecTop dut_i (
      .clk       (clk),
      .rstN      (rstN),
      .instrValid(instrValid),
      .instr     (instr),
      .regData1  (regData1),
      .regData2  (regData2),
      .incPc     (incPc),
      .outValid  (outValid),
      .result    (result),
      .newPc     (newPc),
      .zero      (zero),
      .ofl       (ofl),
      .memRead   (memRead),
      .memWrite  (memWrite)
   );

   always #10 clk = ~clk;

   // instrValid as the DUT sampled it on the last edge
   always @(posedge clk) validSeen <= instrValid;

   function automatic wordT rand16();
      logic [31:0] r;
      r = $urandom();
      return r[15:0];
   endfunction

   function automatic logic [10:0] rand11();
      logic [31:0] r;
      r = $urandom();
      return r[10:0];
   endfunction

   function automatic wordT rotl(input wordT x, input int n);
      wordT r;
      for (int i = 0; i < 16; i++) begin
         r[(i + n) % 16] = x[i];
      end
      return r;
   endfunction

   // signed overflow when the true sum leaves the 16-bit range
   function automatic logic addOvf(input wordT x, input wordT y);
      int s;
      s = int'($signed(x)) + int'($signed(y));
      return (s > 32767) || (s < -32768);
   endfunction

   // same for the true difference x - y
   function automatic logic subOvf(input wordT x, input wordT y);
      int d;
      d = int'($signed(x)) - int'($signed(y));
      return (d > 32767) || (d < -32768);
   endfunction

   function automatic expT refExec(input wordT ins, input wordT rs, input wordT rt,
                                   input wordT pc);
      expT         e;
      opcodeT      op;
      logic [1:0]  fn;
      wordT        i5s, i5z, i8s, d11s;
      logic [16:0] wide;
      int          amtI, amtR;
      op   = ins[15:11];
      fn   = ins[1:0];
      i5s  = {{11{ins[4]}}, ins[4:0]};
      i5z  = {11'b0, ins[4:0]};
      i8s  = {{8{ins[7]}}, ins[7:0]};
      d11s = {{5{ins[10]}}, ins[10:0]};
      amtI = int'(ins[3:0]);
      amtR = int'(rt[3:0]);
      e.instr    = ins;
      e.result   = '0;
      e.newPc    = pc;
      e.ofl      = 1'b0;
      e.memRead  = 1'b0;
      e.memWrite = 1'b0;
      case (op)
         `OP_ADDI: begin
            e.result = rs + i5s;
            e.ofl    = addOvf(rs, i5s);
         end
         `OP_SUBI: begin
            e.result = i5s - rs;
            e.ofl    = subOvf(i5s, rs);
         end
         `OP_XORI:  e.result = rs ^ i5z;
         `OP_ANDNI: e.result = rs & ~i5z;
         `OP_ROLI:  e.result = rotl(rs, amtI);
         `OP_SLLI:  e.result = rs << amtI;
         `OP_RORI:  e.result = rotl(rs, (16 - amtI) % 16);
         `OP_SRLI:  e.result = rs >> amtI;
         `OP_ST: begin
            e.result   = rs + i5s;
            e.memWrite = 1'b1;
         end
         `OP_LD: begin
            e.result  = rs + i5s;
            e.memRead = 1'b1;
         end
         `OP_RALU: begin
            case (fn)
               `FN_ADD: begin
                  e.result = rs + rt;
                  e.ofl    = addOvf(rs, rt);
               end
               `FN_SUB: begin
                  e.result = rt - rs;
                  e.ofl    = subOvf(rt, rs);
               end
               `FN_XOR: e.result = rs ^ rt;
               default: e.result = rs & ~rt;
            endcase
         end
         `OP_RSHF: begin
            case (fn)
               `FN_ROL: e.result = rotl(rs, amtR);
               `FN_SLL: e.result = rs << amtR;
               `FN_ROR: e.result = rotl(rs, (16 - amtR) % 16);
               default: e.result = rs >> amtR;
            endcase
         end
         `OP_BTR:  e.result = {<<{rs}};
         `OP_SEQ: e.result = {15'b0, rs == rt};
         `OP_SLT: e.result = {15'b0, $signed(rs) < $signed(rt)};
         `OP_SLE: e.result = {15'b0, $signed(rs) <= $signed(rt)};
         `OP_SCO: begin
            wide     = {1'b0, rs} + {1'b0, rt};
            e.result = {15'b0, wide[16]};
         end
         `OP_BEQZ: e.newPc = (rs == '0) ? pc + i8s : pc;
         `OP_BNEZ: e.newPc = (rs != '0) ? pc + i8s : pc;
         `OP_BLTZ: e.newPc = rs[15] ? pc + i8s : pc;
         `OP_BGEZ: e.newPc = !rs[15] ? pc + i8s : pc;
         `OP_LBI:  e.result = i8s;
         `OP_SLBI: e.result = {rs[7:0], ins[7:0]};
         `OP_J:    e.newPc = pc + d11s;
         `OP_JAL: begin
            e.newPc  = pc + d11s;
            e.result = pc;
         end
         `OP_JR:   e.newPc = rs + i8s;
         `OP_JALR: begin
            e.newPc  = rs + i8s;
            e.result = pc;
         end
         default: ;
      endcase
      e.zero = (e.result == '0);
      return e;
   endfunction

   task automatic checkField(input string name, input wordT got, input wordT exp,
                             input wordT ins);
      checkCnt++;
      assert (got === exp) else begin
         mismatchCnt++;
         $display("mismatch %s: got %h expected %h (instr %h)", name, got, exp, ins);
      end
   endtask

   // compare on the falling edge where outputs are stable
   always @(negedge clk) begin : compare
      expT e;
      if (rstN) begin
         checkField("outValid", {15'b0, outValid}, {15'b0, validSeen}, instr);
         if (outValid && expQ.size() == 0) begin
            otherErrCnt++;
            $display("outValid pulse with no instruction pending");
         end else if (outValid) begin
            e = expQ.pop_front();
            checkField("result", result, e.result, e.instr);
            checkField("newPc", newPc, e.newPc, e.instr);
            checkField("zero", {15'b0, zero}, {15'b0, e.zero}, e.instr);
            checkField("ofl", {15'b0, ofl}, {15'b0, e.ofl}, e.instr);
            checkField("memRead", {15'b0, memRead}, {15'b0, e.memRead}, e.instr);
            checkField("memWrite", {15'b0, memWrite}, {15'b0, e.memWrite}, e.instr);
         end else begin
            checkField("memRead", {15'b0, memRead}, 16'h0, instr);
            checkField("memWrite", {15'b0, memWrite}, 16'h0, instr);
            checkField("zero", {15'b0, zero}, 16'h0, instr);
            checkField("ofl", {15'b0, ofl}, 16'h0, instr);
         end
      end
   end

   task automatic issueInstr(input opcodeT op, input logic [10:0] low, input wordT rs,
                             input wordT rt);
      wordT ins;
      wordT pc;
      ins = {op, low};
      pc  = rand16();
      @(posedge clk);
      instrValid <= 1'b1;
      instr      <= ins;
      regData1   <= rs;
      regData2   <= rt;
      incPc      <= pc;
      expQ.push_back(refExec(ins, rs, rt, pc));
   endtask

   task automatic idleCycles(input int n);
      repeat (n) begin
         @(posedge clk);
         instrValid <= 1'b0;
      end
   endtask

   task automatic runRandom(input opcodeT op, input int n);
      repeat (n) issueInstr(op, rand11(), rand16(), rand16());
   endtask

   // go idle and wait until every issued instruction has been compared
   task automatic drainQueue(input int limit);
      int cnt;
      cnt = 0;
      idleCycles(1);
      while (expQ.size() != 0 && cnt < limit) begin
         @(posedge clk);
         cnt++;
      end
      if (expQ.size() != 0) begin
         otherErrCnt++;
         $display("timeout with %0d instructions still pending", expQ.size());
      end
   endtask

   initial begin
      seedRet    = $urandom(32'hb2f3_a5d6);
      rstN       = 1'b0;
      instrValid = 1'b0;
      instr      = '0;
      regData1   = '0;
      regData2   = '0;
      incPc      = '0;
      repeat (8) @(posedge clk);
      rstN <= 1'b1;

      // data outputs read zero after reset
      idleCycles(6);
      @(negedge clk);
      checkField("result", result, 16'h0, instr);
      checkField("newPc", newPc, 16'h0, instr);

      // arithmetic and logic with overflow and zero corners first
      issueInstr(`OP_RALU, {9'b0, `FN_ADD}, 16'h7fff, 16'h0001);
      issueInstr(`OP_RALU, {9'b0, `FN_SUB}, 16'h0001, 16'h8000);
      issueInstr(`OP_RALU, {9'b0, `FN_SUB}, 16'h1234, 16'h1234);
      issueInstr(`OP_RALU, {9'b0, `FN_ANDN}, 16'h00f0, 16'h00f0);
      issueInstr(`OP_ADDI, 11'h01d, 16'h0003, rand16());
      issueInstr(`OP_ADDI, 11'h001, 16'h7fff, rand16());
      issueInstr(`OP_SUBI, 11'h000, 16'h8000, rand16());
      issueInstr(`OP_XORI, 11'h015, 16'h0015, rand16());
      issueInstr(`OP_ANDNI, 11'h01f, 16'h001f, rand16());
      runRandom(`OP_ADDI, 12);
      runRandom(`OP_SUBI, 12);
      runRandom(`OP_XORI, 12);
      runRandom(`OP_ANDNI, 12);
      runRandom(`OP_RALU, 24);
      drainQueue(10);

      // shifts and rotates by 0 and 15 followed by bit reverse
      issueInstr(`OP_ROLI, 11'h000, 16'h8001, rand16());
      issueInstr(`OP_ROLI, 11'h00f, 16'h8001, rand16());
      issueInstr(`OP_SLLI, 11'h000, 16'h8001, rand16());
      issueInstr(`OP_SLLI, 11'h00f, 16'h8001, rand16());
      issueInstr(`OP_RORI, 11'h000, 16'h8001, rand16());
      issueInstr(`OP_RORI, 11'h00f, 16'h8001, rand16());
      issueInstr(`OP_SRLI, 11'h000, 16'h8001, rand16());
      issueInstr(`OP_SRLI, 11'h00f, 16'h8001, rand16());
      for (int f = 0; f < 4; f++) begin
         issueInstr(`OP_RSHF, {9'b0, 2'(f)}, 16'h8001, 16'h0000);
         issueInstr(`OP_RSHF, {9'b0, 2'(f)}, 16'h8001, 16'h000f);
      end
      issueInstr(`OP_BTR, rand11(), 16'h0001, rand16());
      runRandom(`OP_ROLI, 8);
      runRandom(`OP_SLLI, 8);
      runRandom(`OP_RORI, 8);
      runRandom(`OP_SRLI, 8);
      runRandom(`OP_RSHF, 16);
      runRandom(`OP_BTR, 8);
      drainQueue(10);

      // set instructions on equal and sign-boundary operands
      issueInstr(`OP_SEQ, rand11(), 16'h5a5a, 16'h5a5a);
      issueInstr(`OP_SLT, rand11(), 16'h5a5a, 16'h5a5a);
      issueInstr(`OP_SLE, rand11(), 16'h5a5a, 16'h5a5a);
      issueInstr(`OP_SLT, rand11(), 16'h8000, 16'h7fff);
      issueInstr(`OP_SLT, rand11(), 16'h7fff, 16'h8000);
      issueInstr(`OP_SLE, rand11(), 16'h8000, 16'h7fff);
      issueInstr(`OP_SLE, rand11(), 16'h7fff, 16'h8000);
      issueInstr(`OP_SCO, rand11(), 16'hffff, 16'h0001);
      issueInstr(`OP_SCO, rand11(), 16'h7fff, 16'h0001);
      runRandom(`OP_SEQ, 8);
      runRandom(`OP_SLT, 8);
      runRandom(`OP_SLE, 8);
      runRandom(`OP_SCO, 8);
      runRandom(`OP_LBI, 8);
      runRandom(`OP_SLBI, 8);
      runRandom(`OP_LD, 8);
      runRandom(`OP_ST, 8);
      drainQueue(10);

      // branches taken and not taken followed by jumps
      issueInstr(`OP_BEQZ, rand11(), 16'h0000, rand16());
      issueInstr(`OP_BEQZ, rand11(), 16'h0040, rand16());
      issueInstr(`OP_BNEZ, rand11(), 16'h0000, rand16());
      issueInstr(`OP_BNEZ, rand11(), 16'h0040, rand16());
      issueInstr(`OP_BLTZ, rand11(), 16'h8000, rand16());
      issueInstr(`OP_BLTZ, rand11(), 16'h7fff, rand16());
      issueInstr(`OP_BGEZ, rand11(), 16'h8000, rand16());
      issueInstr(`OP_BGEZ, rand11(), 16'h7fff, rand16());
      runRandom(`OP_BEQZ, 4);
      runRandom(`OP_BLTZ, 4);
      runRandom(`OP_J, 6);
      runRandom(`OP_JAL, 6);
      runRandom(`OP_JR, 6);
      runRandom(`OP_JALR, 6);
      drainQueue(10);

      // back-to-back random stream with random idle gaps
      for (int n = 0; n < 200; n++) begin
         issueInstr(opcodeT'(rand16() & 16'h001f), rand11(), rand16(), rand16());
         if ($urandom_range(3) == 0) idleCycles(1 + int'($urandom_range(2)));
      end
      drainQueue(10);
      idleCycles(3);

      $display("checks %0d, mismatches %0d, other errors %0d",
               checkCnt, mismatchCnt, otherErrCnt);
      if (mismatchCnt == 0 && otherErrCnt == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

/* compile.f */
+incdir+include
src/wiscPkg.sv
src/claAdder16.sv
src/aluCore.sv
src/instrDecode.sv
src/executeStage.sv
src/resultStage.sv
src/wiscExecTop.sv
tests/execTb.sv

/* run.sh */
#!/bin/sh
# Builds the decode and execute testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module execTb -f compile.f -o execSim

out=$(./obj_dir/execSim)
echo "$out"

if echo "$out" | grep -q "Simulation finished: PASS"; then
   exit 0
else
   exit 1
fi
